//--- vlog.f
+incdir+verilog
verilog/lsq_pkg.sv
verilog/store_forward.sv
verilog/store_queue.sv
verilog/load_queue.sv
verilog/lsq.sv
bench/lsq_checks.sv
bench/lsq_tb.sv

//--- Makefile
.PHONY: run lint clean

run:
	verilator --binary --timing --assert -f vlog.f --top-module lsq_tb -o lsq_sim
	./obj_dir/lsq_sim | tee sim.log
	grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module lsq_tb

clean:
	rm -rf obj_dir sim.log

//--- bench/lsq_tb.sv
module lsq_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int steps = 12;

  logic              clock;
  logic              reset;
  lsq_pkg::mem_op_t  dispatch_op;
  logic              dispatch_ready;
  lsq_pkg::lsq_idx_t sq_idx;
  lsq_pkg::lsq_idx_t lq_idx;
  logic              store_exec_valid;
  lsq_pkg::lsq_idx_t store_exec_idx;
  lsq_pkg::addr_t    store_exec_addr;
  lsq_pkg::data_t    store_exec_data;
  logic              load_exec_valid;
  lsq_pkg::lsq_idx_t load_exec_idx;
  lsq_pkg::addr_t    load_exec_addr;
  logic              retire_store;
  logic              retire_load;
  logic              cache_rd_en;
  lsq_pkg::addr_t    cache_rd_addr;
  logic              cache_rd_valid;
  lsq_pkg::data_t    cache_rd_data;
  logic              cache_wr_en;
  lsq_pkg::addr_t    cache_wr_addr;
  lsq_pkg::data_t    cache_wr_data;
  logic              cache_wr_done;
  logic              load_done;
  lsq_pkg::lsq_idx_t load_done_idx;
  lsq_pkg::data_t    load_data;
  logic              load_forwarded;
  int                check_errors;

  lsq_pkg::lsq_idx_t s [8];
  lsq_pkg::lsq_idx_t l0;
  lsq_pkg::lsq_idx_t l1;
  lsq_pkg::lsq_idx_t l2;

  lsq lsq_i (.*);

  lsq_checks checks_i (.*);

  // Cache read data follows from the address
  assign cache_rd_data = {16'h0000, cache_rd_addr} ^ 32'h0bad_0000;

  initial begin
    clock = 1'b0;
    forever #5 clock = ~clock;
  end

  initial begin
    repeat (steps * 40 + 16) @(posedge clock);
    $display("watchdog expired before the test sequence finished");
    $display("TESTS FAILED");
    $finish;
  end

  task automatic dispatch(input lsq_pkg::mem_op_t op, output lsq_pkg::lsq_idx_t idx);
    idx = (op == lsq_pkg::op_load) ? lq_idx : sq_idx;
    dispatch_op = op;
    @(negedge clock);
    dispatch_op = lsq_pkg::op_none;
  endtask

  task automatic exec_store(input lsq_pkg::lsq_idx_t idx, input lsq_pkg::addr_t addr,
                            input lsq_pkg::data_t data);
    store_exec_valid = 1'b1;
    store_exec_idx = idx;
    store_exec_addr = addr;
    store_exec_data = data;
    @(negedge clock);
    store_exec_valid = 1'b0;
  endtask

  // Reissue until a completion shows up
  task automatic exec_load(input lsq_pkg::lsq_idx_t idx, input lsq_pkg::addr_t addr);
    logic got;
    got = 1'b0;
    while (!got) begin
      load_exec_valid = 1'b1;
      load_exec_idx = idx;
      load_exec_addr = addr;
      cache_rd_valid = 1'($urandom_range(0, 1));
      @(negedge clock);
      load_exec_valid = 1'b0;
      cache_rd_valid = 1'b0;
      got = load_done;
    end
  endtask

  task automatic retire_one_store;
    logic taken;
    taken = 1'b0;
    retire_store = 1'b1;
    while (!taken) begin
      cache_wr_done = 1'($urandom_range(0, 1));
      taken = cache_wr_done;
      @(negedge clock);
    end
    retire_store = 1'b0;
    cache_wr_done = 1'b0;
  endtask

  task automatic retire_one_load;
    retire_load = 1'b1;
    @(negedge clock);
    retire_load = 1'b0;
  endtask

  initial begin
    void'($urandom(32'h50ad_4adc));
    reset = 1'b1;
    dispatch_op = lsq_pkg::op_none;
    store_exec_valid = 1'b0;
    store_exec_idx = '0;
    store_exec_addr = '0;
    store_exec_data = '0;
    load_exec_valid = 1'b0;
    load_exec_idx = '0;
    load_exec_addr = '0;
    retire_store = 1'b0;
    retire_load = 1'b0;
    cache_rd_valid = 1'b0;
    cache_wr_done = 1'b0;
    repeat (16) @(negedge clock);
    reset = 1'b0;
    @(negedge clock);

    // Fill the store ring, then try one store too many
    for (int i = 0; i < 7; i++) begin
      dispatch(lsq_pkg::op_store, s[i]);
    end
    dispatch_op = lsq_pkg::op_store;
    @(negedge clock);
    dispatch(lsq_pkg::op_load, l0);
    for (int i = 0; i < 7; i++) begin
      exec_store(s[i], lsq_pkg::addr_t'(16'h0010 + i), $urandom());
    end
    exec_load(l0, 16'h0013);
    for (int i = 0; i < 7; i++) begin
      retire_one_store();
    end
    retire_one_load();

    // Two stores to one address across the wrap of slot 7 to 0
    dispatch(lsq_pkg::op_store, s[0]);
    dispatch(lsq_pkg::op_store, s[1]);
    exec_store(s[0], 16'h0040, $urandom());
    exec_store(s[1], 16'h0040, $urandom());
    dispatch(lsq_pkg::op_load, l0);
    exec_load(l0, 16'h0040);

    // Store without address before the load, matching store after it
    dispatch(lsq_pkg::op_store, s[2]);
    dispatch(lsq_pkg::op_load, l1);
    dispatch(lsq_pkg::op_store, s[3]);
    exec_store(s[3], 16'h0050, $urandom());
    exec_load(l1, 16'h0050);
    exec_store(s[2], 16'h0060, $urandom());
    dispatch(lsq_pkg::op_load, l2);
    exec_load(l2, 16'h0060);

    for (int i = 0; i < 4; i++) begin
      retire_one_store();
    end
    for (int i = 0; i < 3; i++) begin
      retire_one_load();
    end
    repeat (2) @(negedge clock);

    $display("checks finished with %0d errors", check_errors);
    if (check_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

//--- bench/lsq_checks.sv
`include "lsq_params.svh"

module lsq_checks (
  input  logic              clock,
  input  logic              reset,
  input  lsq_pkg::mem_op_t  dispatch_op,
  input  logic              dispatch_ready,
  input  lsq_pkg::lsq_idx_t sq_idx,
  input  lsq_pkg::lsq_idx_t lq_idx,
  input  logic              store_exec_valid,
  input  lsq_pkg::lsq_idx_t store_exec_idx,
  input  lsq_pkg::addr_t    store_exec_addr,
  input  lsq_pkg::data_t    store_exec_data,
  input  logic              load_exec_valid,
  input  lsq_pkg::lsq_idx_t load_exec_idx,
  input  lsq_pkg::addr_t    load_exec_addr,
  input  logic              retire_store,
  input  logic              retire_load,
  input  logic              cache_rd_en,
  input  logic              cache_rd_valid,
  input  logic              cache_wr_en,
  input  lsq_pkg::addr_t    cache_wr_addr,
  input  lsq_pkg::data_t    cache_wr_data,
  input  logic              cache_wr_done,
  input  logic              load_done,
  input  lsq_pkg::lsq_idx_t load_done_idx,
  input  lsq_pkg::data_t    load_data,
  input  logic              load_forwarded,
  output int                check_errors
);

  timeunit 1ns;
  timeprecision 1ps;

  // Reference store ring
  lsq_pkg::addr_t        ref_addr [`LSQ_DEPTH];
  lsq_pkg::data_t        ref_data [`LSQ_DEPTH];
  logic [`LSQ_DEPTH-1:0] ref_av;
  lsq_pkg::lsq_idx_t     sq_head_r;
  lsq_pkg::lsq_idx_t     sq_tail_r;
  lsq_pkg::lsq_idx_t     sq_cnt;

  // Reference load ring with the store bound of each load
  lsq_pkg::lsq_idx_t bounds [`LSQ_DEPTH];
  lsq_pkg::lsq_idx_t lq_head_r;
  lsq_pkg::lsq_idx_t lq_tail_r;
  lsq_pkg::lsq_idx_t lq_cnt;

  logic              exp_hit;
  lsq_pkg::data_t    exp_data;
  logic              last_exp_hit;
  lsq_pkg::data_t    last_exp_data;
  lsq_pkg::lsq_idx_t last_exec_idx;
  int                errors = 0;

  assign check_errors = errors;
  assign sq_cnt = sq_tail_r - sq_head_r;
  assign lq_cnt = lq_tail_r - lq_head_r;

  // Search down from just below the bound so the first match is the youngest
  always_comb begin
    lsq_pkg::lsq_idx_t span;
    lsq_pkg::lsq_idx_t k;
    span = bounds[load_exec_idx] - sq_head_r;
    exp_hit = 1'b0;
    exp_data = {16'h0000, load_exec_addr} ^ 32'h0bad_0000;
    for (int j = 1; j < `LSQ_DEPTH; j++) begin
      k = bounds[load_exec_idx] - lsq_pkg::lsq_idx_t'(j);
      if (!exp_hit && (lsq_pkg::lsq_idx_t'(j) <= span) && ref_av[k] &&
          (ref_addr[k] == load_exec_addr)) begin
        exp_hit = 1'b1;
        exp_data = ref_data[k];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      sq_head_r <= '0;
      sq_tail_r <= '0;
      lq_head_r <= '0;
      lq_tail_r <= '0;
      ref_av <= '0;
    end else begin
      if ((dispatch_op == lsq_pkg::op_store) && (sq_cnt != 3'd7)) begin
        ref_av[sq_tail_r] <= 1'b0;
        sq_tail_r <= sq_tail_r + 1'b1;
      end
      if ((dispatch_op == lsq_pkg::op_load) && (lq_cnt != 3'd7)) begin
        bounds[lq_tail_r] <= sq_tail_r;
        lq_tail_r <= lq_tail_r + 1'b1;
      end
      if (store_exec_valid) begin
        ref_av[store_exec_idx] <= 1'b1;
        ref_addr[store_exec_idx] <= store_exec_addr;
        ref_data[store_exec_idx] <= store_exec_data;
      end
      if (retire_store && cache_wr_done) begin
        sq_head_r <= sq_head_r + 1'b1;
      end
      if (retire_load) begin
        lq_head_r <= lq_head_r + 1'b1;
      end
    end
    last_exp_hit <= exp_hit;
    last_exp_data <= exp_data;
    last_exec_idx <= load_exec_idx;
  end

  a_reset_idle: assert property (
    @(posedge clock) $fell(reset) |->
      !cache_rd_en && !cache_wr_en && !load_done && (sq_idx == '0) && (lq_idx == '0)
  ) else begin
    errors++;
    $display("outputs not idle or indexes not zero right after reset");
  end

  a_sq_idx: assert property (
    @(posedge clock) disable iff (reset) sq_idx == sq_tail_r
  ) else begin
    errors++;
    $display("FAILED sq_idx: got %h expected %h", $sampled(sq_idx), $sampled(sq_tail_r));
  end

  a_lq_idx: assert property (
    @(posedge clock) disable iff (reset) lq_idx == lq_tail_r
  ) else begin
    errors++;
    $display("FAILED lq_idx: got %h expected %h", $sampled(lq_idx), $sampled(lq_tail_r));
  end

  a_store_full: assert property (
    @(posedge clock) disable iff (reset)
    (dispatch_op == lsq_pkg::op_store) && (sq_cnt == 3'd7) |-> !dispatch_ready
  ) else begin
    errors++;
    $display("FAILED dispatch_ready: got %h expected %h", $sampled(dispatch_ready), 1'b0);
  end

  a_load_ready: assert property (
    @(posedge clock) disable iff (reset)
    (dispatch_op == lsq_pkg::op_load) && (lq_cnt != 3'd7) |-> dispatch_ready
  ) else begin
    errors++;
    $display("FAILED dispatch_ready: got %h expected %h", $sampled(dispatch_ready), 1'b1);
  end

  // Cache read only for an executing load that no older store forwards
  a_cache_read: assert property (
    @(posedge clock) disable iff (reset) cache_rd_en == (load_exec_valid && !exp_hit)
  ) else begin
    errors++;
    $display("FAILED cache_rd_en: got %h expected %h",
             $sampled(cache_rd_en), $sampled(load_exec_valid && !exp_hit));
  end

  a_load_done: assert property (
    @(posedge clock) disable iff (reset)
    load_exec_valid && (exp_hit || cache_rd_valid) |=> load_done
  ) else begin
    errors++;
    $display("FAILED load_done: got %h expected %h", $sampled(load_done), 1'b1);
  end

  a_no_done: assert property (
    @(posedge clock) disable iff (reset)
    !(load_exec_valid && (exp_hit || cache_rd_valid)) |=> !load_done
  ) else begin
    errors++;
    $display("FAILED load_done: got %h expected %h", $sampled(load_done), 1'b0);
  end

  a_load_done_idx: assert property (
    @(posedge clock) disable iff (reset)
    load_exec_valid && (exp_hit || cache_rd_valid) |=> load_done_idx == last_exec_idx
  ) else begin
    errors++;
    $display("FAILED load_done_idx: got %h expected %h",
             $sampled(load_done_idx), $sampled(last_exec_idx));
  end

  a_load_data: assert property (
    @(posedge clock) disable iff (reset)
    load_exec_valid && (exp_hit || cache_rd_valid) |=> load_data == last_exp_data
  ) else begin
    errors++;
    $display("FAILED load_data: got %h expected %h",
             $sampled(load_data), $sampled(last_exp_data));
  end

  a_load_forwarded: assert property (
    @(posedge clock) disable iff (reset)
    load_exec_valid && (exp_hit || cache_rd_valid) |=> load_forwarded == last_exp_hit
  ) else begin
    errors++;
    $display("FAILED load_forwarded: got %h expected %h",
             $sampled(load_forwarded), $sampled(last_exp_hit));
  end

  // Head write repeats until the cache takes it
  a_cache_write: assert property (
    @(posedge clock) disable iff (reset)
    retire_store |-> cache_wr_en && (cache_wr_addr == ref_addr[sq_head_r]) &&
      (cache_wr_data == ref_data[sq_head_r])
  ) else begin
    errors++;
    $display("FAILED cache_wr_addr/cache_wr_data: got %h/%h expected %h/%h",
             $sampled(cache_wr_addr), $sampled(cache_wr_data),
             $sampled(ref_addr[sq_head_r]), $sampled(ref_data[sq_head_r]));
  end

endmodule

//--- verilog/lsq.sv
module lsq (
  input  logic              clock,
  input  logic              reset,
  input  lsq_pkg::mem_op_t  dispatch_op,
  output logic              dispatch_ready,
  output lsq_pkg::lsq_idx_t sq_idx,
  output lsq_pkg::lsq_idx_t lq_idx,
  input  logic              store_exec_valid,
  input  lsq_pkg::lsq_idx_t store_exec_idx,
  input  lsq_pkg::addr_t    store_exec_addr,
  input  lsq_pkg::data_t    store_exec_data,
  input  logic              load_exec_valid,
  input  lsq_pkg::lsq_idx_t load_exec_idx,
  input  lsq_pkg::addr_t    load_exec_addr,
  input  logic              retire_store,
  input  logic              retire_load,
  output logic              cache_rd_en,
  output lsq_pkg::addr_t    cache_rd_addr,
  input  logic              cache_rd_valid,
  input  lsq_pkg::data_t    cache_rd_data,
  output logic              cache_wr_en,
  output lsq_pkg::addr_t    cache_wr_addr,
  output lsq_pkg::data_t    cache_wr_data,
  input  logic              cache_wr_done,
  output logic              load_done,
  output lsq_pkg::lsq_idx_t load_done_idx,
  output lsq_pkg::data_t    load_data,
  output logic              load_forwarded
);

  logic              sq_full;
  logic              lq_full;
  logic              sq_alloc;
  logic              lq_alloc;
  lsq_pkg::lsq_idx_t fwd_bound;
  logic              fwd_hit;
  lsq_pkg::data_t    fwd_data;

  always_comb begin
    case (dispatch_op)
      lsq_pkg::op_load:  dispatch_ready = !lq_full;
      lsq_pkg::op_store: dispatch_ready = !sq_full;
      default:           dispatch_ready = 1'b1;
    endcase
  end

  assign sq_alloc = (dispatch_op == lsq_pkg::op_store) && !sq_full;
  assign lq_alloc = (dispatch_op == lsq_pkg::op_load) && !lq_full;

  store_queue store_queue_i (
    .clock         (clock),
    .reset         (reset),
    .alloc         (sq_alloc),
    .full          (sq_full),
    .tail          (sq_idx),
    .exec_valid    (store_exec_valid),
    .exec_idx      (store_exec_idx),
    .exec_addr     (store_exec_addr),
    .exec_data     (store_exec_data),
    .fwd_addr      (load_exec_addr),
    .fwd_bound     (fwd_bound),
    .fwd_hit       (fwd_hit),
    .fwd_data      (fwd_data),
    .retire        (retire_store),
    .cache_wr_en   (cache_wr_en),
    .cache_wr_addr (cache_wr_addr),
    .cache_wr_data (cache_wr_data),
    .cache_wr_done (cache_wr_done)
  );

  // Loads take the store tail as their age bound
  load_queue load_queue_i (
    .clock          (clock),
    .reset          (reset),
    .alloc          (lq_alloc),
    .sq_tail        (sq_idx),
    .full           (lq_full),
    .tail           (lq_idx),
    .exec_valid     (load_exec_valid),
    .exec_idx       (load_exec_idx),
    .exec_addr      (load_exec_addr),
    .fwd_bound      (fwd_bound),
    .fwd_hit        (fwd_hit),
    .fwd_data       (fwd_data),
    .cache_rd_en    (cache_rd_en),
    .cache_rd_addr  (cache_rd_addr),
    .cache_rd_valid (cache_rd_valid),
    .cache_rd_data  (cache_rd_data),
    .retire         (retire_load),
    .load_done      (load_done),
    .load_forwarded (load_forwarded),
    .load_done_idx  (load_done_idx),
    .load_data      (load_data)
  );

endmodule

//--- verilog/load_queue.sv
`include "lsq_params.svh"

module load_queue (
  input  logic              clock,
  input  logic              reset,
  input  logic              alloc,
  input  lsq_pkg::lsq_idx_t sq_tail,
  output logic              full,
  output lsq_pkg::lsq_idx_t tail,
  input  logic              exec_valid,
  input  lsq_pkg::lsq_idx_t exec_idx,
  input  lsq_pkg::addr_t    exec_addr,
  output lsq_pkg::lsq_idx_t fwd_bound,
  input  logic              fwd_hit,
  input  lsq_pkg::data_t    fwd_data,
  output logic              cache_rd_en,
  output lsq_pkg::addr_t    cache_rd_addr,
  input  logic              cache_rd_valid,
  input  lsq_pkg::data_t    cache_rd_data,
  input  logic              retire,
  output logic              load_done,
  output logic              load_forwarded,
  output lsq_pkg::lsq_idx_t load_done_idx,
  output lsq_pkg::data_t    load_data
);

  // Store queue tail captured at dispatch of each load
  lsq_pkg::lsq_idx_t bounds [`LSQ_DEPTH];
  logic [`LSQ_DEPTH-1:0] done;
  lsq_pkg::lsq_idx_t head;
  lsq_pkg::lsq_idx_t count;
  lsq_pkg::lsq_idx_t exec_offset;
  logic success;

  assign count = tail - head;
  assign full = (count == lsq_pkg::lsq_idx_t'(`LSQ_DEPTH - 1));
  assign exec_offset = exec_idx - head;

  assign fwd_bound = bounds[exec_idx];

  // Cache is only asked when no older store forwards
  assign cache_rd_en = exec_valid && !fwd_hit;
  assign cache_rd_addr = exec_addr;
  assign success = exec_valid && (fwd_hit || cache_rd_valid);

  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
      done <= '0;
      load_done <= 1'b0;
    end else begin
      if (alloc) begin
        tail <= tail + 1'b1;
        done[tail] <= 1'b0;
      end
      if (success) begin
        done[exec_idx] <= 1'b1;
      end
      if (retire) begin
        head <= head + 1'b1;
      end
      load_done <= success;
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) begin
      bounds[tail] <= sq_tail;
    end
    if (success) begin
      load_done_idx <= exec_idx;
      load_forwarded <= fwd_hit;
      load_data <= fwd_hit ? fwd_data : cache_rd_data;
    end
  end

  a_exec_occupied: assert property (
    @(posedge clock) disable iff (reset)
    exec_valid |-> (exec_offset < count)
  ) else $error("load execute at idx %0h outside head %0h tail %0h", exec_idx, head, tail);

  a_retire_done: assert property (
    @(posedge clock) disable iff (reset)
    retire |-> (count != '0) && done[head]
  ) else $error("load retire at head %0h before completion", head);

endmodule

//--- verilog/store_queue.sv
`include "lsq_params.svh"

module store_queue (
  input  logic              clock,
  input  logic              reset,
  input  logic              alloc,
  output logic              full,
  output lsq_pkg::lsq_idx_t tail,
  input  logic              exec_valid,
  input  lsq_pkg::lsq_idx_t exec_idx,
  input  lsq_pkg::addr_t    exec_addr,
  input  lsq_pkg::data_t    exec_data,
  input  lsq_pkg::addr_t    fwd_addr,
  input  lsq_pkg::lsq_idx_t fwd_bound,
  output logic              fwd_hit,
  output lsq_pkg::data_t    fwd_data,
  input  logic              retire,
  output logic              cache_wr_en,
  output lsq_pkg::addr_t    cache_wr_addr,
  output lsq_pkg::data_t    cache_wr_data,
  input  logic              cache_wr_done
);

  lsq_pkg::sq_entry_t entries [`LSQ_DEPTH];
  lsq_pkg::lsq_idx_t  head;
  lsq_pkg::lsq_idx_t  count;
  lsq_pkg::lsq_idx_t  exec_offset;
  lsq_pkg::lsq_idx_t  fwd_idx;

  assign count = tail - head;
  assign full = (count == lsq_pkg::lsq_idx_t'(`LSQ_DEPTH - 1));
  assign exec_offset = exec_idx - head;

  // Head only moves once the cache takes the write
  always_ff @(posedge clock) begin
    if (reset) begin
      head <= '0;
      tail <= '0;
    end else begin
      if (alloc) begin
        tail <= tail + 1'b1;
      end
      if (retire && cache_wr_done) begin
        head <= head + 1'b1;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (alloc) begin
      entries[tail].addr_valid <= 1'b0;
    end
    if (exec_valid) begin
      entries[exec_idx] <= '{addr_valid: 1'b1, addr: exec_addr, data: exec_data};
    end
  end

  // Retire write comes straight from the head entry
  assign cache_wr_en = retire;
  assign cache_wr_addr = entries[head].addr;
  assign cache_wr_data = entries[head].data;

  store_forward store_forward_i (
    .head    (head),
    .bound   (fwd_bound),
    .entries (entries),
    .addr    (fwd_addr),
    .hit     (fwd_hit),
    .hit_idx (fwd_idx)
  );

  assign fwd_data = entries[fwd_idx].data;

  a_exec_occupied: assert property (
    @(posedge clock) disable iff (reset)
    exec_valid |-> (exec_offset < count)
  ) else $error("store execute at idx %0h outside head %0h tail %0h", exec_idx, head, tail);

  a_retire_addr_valid: assert property (
    @(posedge clock) disable iff (reset)
    retire |-> (count != '0) && entries[head].addr_valid
  ) else $error("store retire at head %0h without an address", head);

  // Dispatch readiness is formed at the top level
  a_alloc_not_full: assert property (
    @(posedge clock) disable iff (reset)
    alloc |-> !full
  ) else $error("store alloc while full");

endmodule

//--- verilog/store_forward.sv
`include "lsq_params.svh"

module store_forward (
  input  lsq_pkg::lsq_idx_t  head,
  input  lsq_pkg::lsq_idx_t  bound,
  input  lsq_pkg::sq_entry_t entries [`LSQ_DEPTH],
  input  lsq_pkg::addr_t     addr,
  output logic               hit,
  output lsq_pkg::lsq_idx_t  hit_idx
);

  // Stores older than the load, counted from head
  lsq_pkg::lsq_idx_t span;

  // Address match per slot, in slot order
  logic [`LSQ_DEPTH-1:0] match;

  assign span = bound - head;

  always_comb begin
    for (int i = 0; i < `LSQ_DEPTH; i++) begin
      match[i] = entries[i].addr_valid && (entries[i].addr == addr);
    end
  end

  // Walk oldest to youngest so the last match is the youngest one
  always_comb begin
    lsq_pkg::lsq_idx_t offset;
    lsq_pkg::lsq_idx_t idx;
    hit = 1'b0;
    hit_idx = head;
    for (int j = 0; j < `LSQ_DEPTH; j++) begin
      offset = lsq_pkg::lsq_idx_t'(j);
      idx = head + offset;
      if ((offset < span) && match[idx]) begin
        hit = 1'b1;
        hit_idx = idx;
      end
    end
  end

endmodule

//--- verilog/lsq_pkg.sv
`include "lsq_params.svh"

package lsq_pkg;

  typedef logic [$clog2(`LSQ_DEPTH)-1:0] lsq_idx_t;

  typedef logic [`LSQ_ADDR_W-1:0] addr_t;

  typedef logic [`LSQ_DATA_W-1:0] data_t;

  // Operation presented on the dispatch slot
  typedef enum logic [1:0] {
    op_none,
    op_load,
    op_store
  } mem_op_t;

  typedef struct packed {
    logic  addr_valid;
    addr_t addr;
    data_t data;
  } sq_entry_t;

endpackage

//--- verilog/lsq_params.svh
`ifndef LSQ_PARAMS_SVH
`define LSQ_PARAMS_SVH

// Entries per ring, one always kept free
`define LSQ_DEPTH 8

// Word address width
`define LSQ_ADDR_W 16

// Data word width
`define LSQ_DATA_W 32

`endif
